// File: rtl/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // Address and block geometry
    localparam int ADDR_BITS         = 32;
    localparam int ITAG_BITS         = 13;
    localparam int BLOCK_OFFSET_BITS = 3;
    localparam int BLOCK_BITS        = 64;

    // Cache organization
    localparam int ICACHE_LINES    = 8;
    localparam int LINE_INDEX_BITS = 3;

    // Memory tags where zero means no tag
    localparam int MEM_TAG_BITS  = 4;
    localparam int MSHR_DEPTH    = 16;
    localparam int MSHR_PTR_BITS = 4;

    // Eviction LFSR start value that must not be zero
    localparam logic [LINE_INDEX_BITS-1:0] LFSR_SEED = 3'b101;

    typedef struct packed {
        logic [ADDR_BITS-ITAG_BITS-BLOCK_OFFSET_BITS-1:0] zeros;
        logic [ITAG_BITS-1:0]                             tag;
        logic [BLOCK_OFFSET_BITS-1:0]                     block_offset;
    } i_addr_t;

    typedef struct packed {
        logic    valid;
        i_addr_t addr;
    } fetch_req_t;

    typedef struct packed {
        logic                  valid;
        logic [BLOCK_BITS-1:0] data;
    } fetch_resp_t;

    typedef struct packed {
        logic                  valid;
        logic [ITAG_BITS-1:0]  tag;
        logic [BLOCK_BITS-1:0] data;
    } cache_line_t;

    typedef struct packed {
        logic                    valid;
        logic [MEM_TAG_BITS-1:0] mem_tag;
        logic [ITAG_BITS-1:0]    i_tag;
    } mshr_entry_t;

endpackage

`default_nettype wire

// File: rtl/icache_array.sv
`timescale 1ns/10ps
`default_nettype none

module icache_array
    import icache_pkg::*;
(
    input  wire logic                       clock,
    input  wire logic                       reset,

    // Fetch read ports
    input  wire fetch_req_t  [1:0]          i_read_addrs,
    output      fetch_resp_t [1:0]          o_cache_outs,

    // Miss filter snoop
    input  wire logic [ITAG_BITS-1:0]       i_snoop_tag,
    output      logic                       o_snoop_found,

    // Line write from a returning fill
    input  wire fetch_req_t                 i_fill,
    input  wire logic [BLOCK_BITS-1:0]      i_fill_data,
    input  wire logic [LINE_INDEX_BITS-1:0] i_fill_index,

    output      logic [ICACHE_LINES-1:0]    o_valid_bits
);

    cache_line_t [ICACHE_LINES-1:0]       lines;
    logic [1:0][ICACHE_LINES-1:0]         read_hits;
    logic [ICACHE_LINES-1:0]              snoop_hits;
    logic                                 dup_tag;

    // Line storage and fill write
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < ICACHE_LINES; i++) begin
                lines[i].valid <= 1'b0;
            end
        end else if (i_fill.valid) begin
            lines[i_fill_index].valid <= 1'b1;
            lines[i_fill_index].tag   <= i_fill.addr.tag;
            lines[i_fill_index].data  <= i_fill_data;
        end
    end

    // Tag match per read port against every valid line
    always_comb begin
        for (int j = 0; j < 2; j++) begin
            for (int i = 0; i < ICACHE_LINES; i++) begin
                read_hits[j][i] = i_read_addrs[j].valid && lines[i].valid &&
                                  (lines[i].tag == i_read_addrs[j].addr.tag);
            end
        end
    end

    // At most one line matches, so the blocks can be ORed together
    always_comb begin
        for (int j = 0; j < 2; j++) begin
            o_cache_outs[j] = '0;
            o_cache_outs[j].valid = |read_hits[j];
            for (int i = 0; i < ICACHE_LINES; i++) begin
                if (read_hits[j][i]) begin
                    o_cache_outs[j].data = o_cache_outs[j].data | lines[i].data;
                end
            end
        end
    end

    // Snoop lookup for the miss candidate
    always_comb begin
        for (int i = 0; i < ICACHE_LINES; i++) begin
            snoop_hits[i] = lines[i].valid && (lines[i].tag == i_snoop_tag);
        end
    end

    assign o_snoop_found = |snoop_hits;

    always_comb begin
        for (int i = 0; i < ICACHE_LINES; i++) begin
            o_valid_bits[i] = lines[i].valid;
        end
    end

    // Any pair of valid lines holding the same tag
    always_comb begin
        dup_tag = 1'b0;
        for (int i = 0; i < ICACHE_LINES; i++) begin
            for (int k = i + 1; k < ICACHE_LINES; k++) begin
                if (lines[i].valid && lines[k].valid && (lines[i].tag == lines[k].tag)) begin
                    dup_tag = 1'b1;
                end
            end
        end
    end

    // The filter and the MSHR together keep a tag from being fetched twice
    a_no_duplicate_tags: assert property (
        @(posedge clock) disable iff (reset) !dup_tag
    ) else $error("icache_array: two valid lines hold the same tag");

endmodule

`default_nettype wire

// File: rtl/icache_victim_select.sv
`timescale 1ns/10ps
`default_nettype none

module icache_victim_select
    import icache_pkg::*;
(
    input  wire logic                       clock,
    input  wire logic                       reset,
    input  wire logic [ICACHE_LINES-1:0]    i_valid_bits,
    input  wire logic                       i_fill_valid,
    output      logic [LINE_INDEX_BITS-1:0] o_fill_index
);

    logic [LINE_INDEX_BITS-1:0] lfsr;
    logic [LINE_INDEX_BITS-1:0] free_index;
    logic                       free_found;

    // Free-running x^3 + x^2 + 1 sequence of period 7
    always_ff @(posedge clock) begin
        if (reset) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr <= {lfsr[1:0], lfsr[2] ^ lfsr[1]};
        end
    end

    // Lowest invalid line wins
    always_comb begin
        free_found = 1'b0;
        free_index = '0;
        for (int i = ICACHE_LINES - 1; i >= 0; i--) begin
            if (!i_valid_bits[i]) begin
                free_found = 1'b1;
                free_index = LINE_INDEX_BITS'(i);
            end
        end
    end

    always_comb begin
        if (!i_fill_valid) begin
            o_fill_index = '0;
        end else if (free_found) begin
            o_fill_index = free_index;
        end else begin
            // Evict a pseudo-random line when the cache is full
            o_fill_index = lfsr;
        end
    end

    a_lfsr_nonzero: assert property (
        @(posedge clock) disable iff (reset) lfsr != '0
    ) else $error("icache_victim_select: LFSR locked at zero");

endmodule

`default_nettype wire

// File: rtl/icache_mshr.sv
`timescale 1ns/10ps
`default_nettype none

module icache_mshr
    import icache_pkg::*;
(
    input  wire logic                    clock,
    input  wire logic                    reset,

    // Snoop from the miss filter
    input  wire logic [ITAG_BITS-1:0]    i_snoop_tag,
    output      logic                    o_snoop_found,

    // Accepted memory request
    input  wire fetch_req_t              i_mem_req,
    input  wire logic                    i_mem_req_accepted,
    input  wire logic [MEM_TAG_BITS-1:0] i_current_req_tag,

    // Memory response and resulting line fill
    input  wire logic [MEM_TAG_BITS-1:0] i_mem_data_tag,
    output      fetch_req_t              o_fill
);

    mshr_entry_t [MSHR_DEPTH-1:0] entries;
    logic [MSHR_PTR_BITS-1:0]     head;
    logic [MSHR_PTR_BITS-1:0]     tail;
    mshr_entry_t                  new_entry;
    logic                         push;
    logic                         pop;
    logic [MSHR_DEPTH-1:0]        snoop_hits;

    // Zero tag means memory did not take the request
    assign push = i_mem_req_accepted && i_mem_req.valid && (i_current_req_tag != '0);

    // Responses come back in order, so only the head can match
    assign pop = (i_mem_data_tag != '0) && entries[head].valid &&
                 (entries[head].mem_tag == i_mem_data_tag);

    always_comb begin
        new_entry.valid   = 1'b1;
        new_entry.mem_tag = i_current_req_tag;
        new_entry.i_tag   = i_mem_req.addr.tag;
    end

    // Block-aligned fill address of the popped entry
    always_comb begin
        o_fill = '0;
        if (pop) begin
            o_fill.valid    = 1'b1;
            o_fill.addr.tag = entries[head].i_tag;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            for (int i = 0; i < MSHR_DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            if (pop) begin
                entries[head].valid <= 1'b0;
                head <= head + 1'b1;
            end
            if (push) begin
                entries[tail] <= new_entry;
                tail <= tail + 1'b1;
            end
        end
    end

    // Any outstanding entry for this tag covers the miss
    always_comb begin
        for (int i = 0; i < MSHR_DEPTH; i++) begin
            snoop_hits[i] = entries[i].valid && (entries[i].i_tag == i_snoop_tag);
        end
    end

    assign o_snoop_found = |snoop_hits;

    // Memory hands out at most 15 tags, so the tail slot must be free
    a_push_not_full: assert property (
        @(posedge clock) disable iff (reset) push |-> !entries[tail].valid
    ) else $error("icache_mshr: push onto a valid entry");

endmodule

`default_nettype wire

// File: rtl/icache_miss_filter.sv
`timescale 1ns/10ps
`default_nettype none

module icache_miss_filter
    import icache_pkg::*;
(
    input  wire logic               clock,
    input  wire logic               reset,
    input  wire fetch_req_t  [1:0]  i_read_addrs,
    input  wire fetch_resp_t [1:0]  i_cache_outs,
    input  wire logic               i_found_in_cache,
    input  wire logic               i_found_in_mshr,
    input  wire logic               i_mem_req_accepted,
    output      fetch_req_t         o_snoop_addr,
    output      fetch_req_t         o_mem_req
);

    fetch_req_t oldest_miss;
    fetch_req_t last_accepted;

    // Port 0 holds the older fetch, so it goes first
    always_comb begin
        oldest_miss = '0;
        if (i_read_addrs[0].valid && !i_cache_outs[0].valid) begin
            oldest_miss = i_read_addrs[0];
        end else if (i_read_addrs[1].valid && !i_cache_outs[1].valid) begin
            oldest_miss = i_read_addrs[1];
        end
    end

    // Drop the miss that was just handed to memory
    always_comb begin
        o_snoop_addr = '0;
        if (oldest_miss.valid &&
            (!last_accepted.valid || (oldest_miss.addr != last_accepted.addr))) begin
            o_snoop_addr = oldest_miss;
        end
    end

    // Covered by a line or by an outstanding entry
    always_comb begin
        o_mem_req = '0;
        if (o_snoop_addr.valid && !i_found_in_cache && !i_found_in_mshr) begin
            o_mem_req = o_snoop_addr;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            last_accepted <= '0;
        end else if (i_mem_req_accepted && o_mem_req.valid) begin
            last_accepted <= o_mem_req;
        end
    end

endmodule

`default_nettype wire

// File: rtl/icache_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

module icache_subsystem
    import icache_pkg::*;
(
    input  wire logic                    clock,
    input  wire logic                    reset,

    // Fetch side with port 0 as the older instruction
    input  wire fetch_req_t  [1:0]       i_read_addrs,
    output      fetch_resp_t [1:0]       o_cache_outs,

    // Memory side
    input  wire logic [MEM_TAG_BITS-1:0] i_current_req_tag,
    input  wire logic [BLOCK_BITS-1:0]   i_mem_data,
    input  wire logic [MEM_TAG_BITS-1:0] i_mem_data_tag,
    output      fetch_req_t              o_mem_req,
    input  wire logic                    i_mem_req_accepted
);

    fetch_req_t                 snoop_addr;
    fetch_req_t                 fill;
    logic                       found_in_cache;
    logic                       found_in_mshr;
    logic [ICACHE_LINES-1:0]    valid_bits;
    logic [LINE_INDEX_BITS-1:0] fill_index;

    icache_array icache_array_inst (
        .clock         (clock),
        .reset         (reset),
        .i_read_addrs  (i_read_addrs),
        .o_cache_outs  (o_cache_outs),
        .i_snoop_tag   (snoop_addr.addr.tag),
        .o_snoop_found (found_in_cache),
        .i_fill        (fill),
        .i_fill_data   (i_mem_data),
        .i_fill_index  (fill_index),
        .o_valid_bits  (valid_bits)
    );

    icache_victim_select icache_victim_select_inst (
        .clock        (clock),
        .reset        (reset),
        .i_valid_bits (valid_bits),
        .i_fill_valid (fill.valid),
        .o_fill_index (fill_index)
    );

    icache_mshr icache_mshr_inst (
        .clock              (clock),
        .reset              (reset),
        .i_snoop_tag        (snoop_addr.addr.tag),
        .o_snoop_found      (found_in_mshr),
        .i_mem_req          (o_mem_req),
        .i_mem_req_accepted (i_mem_req_accepted),
        .i_current_req_tag  (i_current_req_tag),
        .i_mem_data_tag     (i_mem_data_tag),
        .o_fill             (fill)
    );

    icache_miss_filter icache_miss_filter_inst (
        .clock              (clock),
        .reset              (reset),
        .i_read_addrs       (i_read_addrs),
        .i_cache_outs       (o_cache_outs),
        .i_found_in_cache   (found_in_cache),
        .i_found_in_mshr    (found_in_mshr),
        .i_mem_req_accepted (i_mem_req_accepted),
        .o_snoop_addr       (snoop_addr),
        .o_mem_req          (o_mem_req)
    );

endmodule

`default_nettype wire

// File: test/clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module clock_gen (
    output logic clock,
    output logic reset
);

    // 40 ns period
    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Reset held over the first four rising edges
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// File: test/icache_subsystem_tb.sv
`timescale 1ns/10ps
`default_nettype none

module icache_subsystem_tb
    import icache_pkg::*;
();

    logic                    clock;
    logic                    reset;
    fetch_req_t  [1:0]       read_addrs;
    fetch_resp_t [1:0]       cache_outs;
    logic [MEM_TAG_BITS-1:0] current_req_tag = 4'd1;
    logic [BLOCK_BITS-1:0]   mem_data = '0;
    logic [MEM_TAG_BITS-1:0] mem_data_tag = '0;
    fetch_req_t              mem_req;
    logic                    mem_req_accepted = 1'b0;

    // Memory model and scoreboard state
    logic [31:0]             case_words [0:95];
    logic [31:0]             lfsr = 32'hf89f;
    logic                    accept_enable = 1'b1;
    logic [MEM_TAG_BITS-1:0] next_tag = 4'd1;
    logic [ITAG_BITS-1:0]    pend_itag [$];
    logic [MEM_TAG_BITS-1:0] pend_mtag [$];
    int                      pend_due [$];
    bit                      ever_filled [0:(1<<ITAG_BITS)-1];
    fetch_req_t              last_acc = '0;
    logic                    returning = 1'b0;
    logic [ITAG_BITS-1:0]    returning_itag = '0;
    logic                    just_filled = 1'b0;
    logic [ITAG_BITS-1:0]    just_filled_itag = '0;
    fetch_req_t              req_sample = '0;
    logic                    acc_sample = 1'b0;
    int                      cycle = 0;
    int                      timeout_limit = 1000;
    int                      sweep_hits = 0;

    clock_gen clock_gen_inst (.clock(clock), .reset(reset));

    icache_subsystem icache_subsystem_inst (
        .clock              (clock),
        .reset              (reset),
        .i_read_addrs       (read_addrs),
        .o_cache_outs       (cache_outs),
        .i_current_req_tag  (current_req_tag),
        .i_mem_data         (mem_data),
        .i_mem_data_tag     (mem_data_tag),
        .o_mem_req          (mem_req),
        .i_mem_req_accepted (mem_req_accepted)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic value_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] expected);
        abort_run($sformatf("FAILED time=%0t %s got=%0h expected=%0h",
                            $time, name, got, expected));
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    // Upper half from the line tag and lower half its inverse
    function automatic logic [BLOCK_BITS-1:0] block_for(input logic [ITAG_BITS-1:0] itag);
        logic [31:0] upper;
        upper = {19'd0, itag} ^ 32'hA5A50000;
        return {upper, ~upper};
    endfunction

    function automatic logic is_pending(input logic [ITAG_BITS-1:0] itag);
        logic found;
        found = 1'b0;
        foreach (pend_itag[i]) begin
            if (pend_itag[i] == itag) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    function automatic logic pair_served(input fetch_req_t [1:0] pair);
        return (!pair[0].valid || cache_outs[0].valid) && (!pair[1].valid || cache_outs[1].valid);
    endfunction

    // Memory model that accepts on random cycles and answers 3 cycles later in order
    always @(posedge clock) begin
        cycle = cycle + 1;
        if (cycle > timeout_limit) begin
            abort_run($sformatf("Timeout: run did not finish within %0d cycles", timeout_limit));
        end else if (reset) begin
            mem_req_accepted <= 1'b0;
            mem_data_tag <= '0;
            mem_data <= '0;
        end else begin
            if (acc_sample && req_sample.valid) begin
                pend_itag.push_back(req_sample.addr.tag);
                pend_mtag.push_back(next_tag);
                pend_due.push_back(cycle + 3);
                last_acc = req_sample;
                next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
            end
            current_req_tag <= next_tag;
            lfsr = lfsr_step(lfsr);
            mem_req_accepted <= accept_enable && lfsr[0];
            just_filled = returning;
            just_filled_itag = returning_itag;
            returning = 1'b0;
            mem_data_tag <= '0;
            mem_data <= '0;
            if (pend_due.size() != 0 && pend_due[0] == cycle) begin
                returning = 1'b1;
                returning_itag = pend_itag.pop_front();
                ever_filled[returning_itag] = 1'b1;
                mem_data_tag <= pend_mtag.pop_front();
                mem_data <= block_for(returning_itag);
                void'(pend_due.pop_front());
            end
        end
    end

    // Checks on the falling edge where all DUT outputs are settled
    always @(negedge clock) begin : checks
        fetch_req_t expect_req;
        logic       covered;
        req_sample = mem_req;
        acc_sample = mem_req_accepted;
        if (!reset) begin
            for (int j = 0; j < 2; j++) begin
                if (cache_outs[j].valid) begin
                    assert (read_addrs[j].valid && ever_filled[read_addrs[j].addr.tag])
                    else abort_run($sformatf("Port %0d hit on a tag memory never returned", j));
                    assert (cache_outs[j].data == block_for(read_addrs[j].addr.tag))
                    else value_mismatch($sformatf("o_cache_outs[%0d].data", j),
                                        cache_outs[j].data, block_for(read_addrs[j].addr.tag));
                end
                // A line filled on the last edge must hit now
                if (just_filled && read_addrs[j].valid &&
                    read_addrs[j].addr.tag == just_filled_itag) begin
                    assert (cache_outs[j].valid)
                    else value_mismatch($sformatf("o_cache_outs[%0d].valid", j),
                                        64'(cache_outs[j].valid), 64'd1);
                end
            end
            // Oldest miss unless memory already has it or it was just accepted
            expect_req = '0;
            if (read_addrs[0].valid && !cache_outs[0].valid) begin
                expect_req = read_addrs[0];
            end else if (read_addrs[1].valid && !cache_outs[1].valid) begin
                expect_req = read_addrs[1];
            end
            covered = is_pending(expect_req.addr.tag) ||
                      (returning && returning_itag == expect_req.addr.tag) ||
                      (last_acc.valid && last_acc.addr == expect_req.addr);
            assert (mem_req.valid == (expect_req.valid && !covered))
            else value_mismatch("o_mem_req.valid", 64'(mem_req.valid),
                                64'(expect_req.valid && !covered));
            assert (!(mem_req.valid && is_pending(mem_req.addr.tag)))
            else abort_run("Memory request repeats a tag that is still outstanding");
            if (mem_req.valid) begin
                assert (mem_req.addr == expect_req.addr)
                else value_mismatch("o_mem_req.addr", mem_req.addr, expect_req.addr);
            end
        end
    end

    initial begin
        int                idx;
        int                num_lines;
        logic [31:0]       ctrl;
        fetch_req_t [1:0]  pair;
        read_addrs = '0;
        $readmemh("test/icache_cases.txt", case_words);
        idx = 0;
        num_lines = 0;
        while (idx < 96 && case_words[idx] !== 32'hF000_0000) begin
            num_lines++;
            idx += 3;
        end
        assert (idx < 96) else abort_run("No end marker found in test/icache_cases.txt");
        timeout_limit = 40 * (num_lines + 1);
        do @(negedge clock); while (reset);
        for (idx = 0; case_words[idx] !== 32'hF000_0000; idx += 3) begin
            ctrl = case_words[idx];
            pair[0].valid = ctrl[0];
            pair[0].addr = case_words[idx + 1];
            pair[1].valid = ctrl[1];
            pair[1].addr = case_words[idx + 2];
            case (ctrl[31:28])
                4'h1: accept_enable = 1'b1;
                4'h2: begin
                    // Sweep with memory shut off after draining what is in flight
                    accept_enable = 1'b0;
                    sweep_hits = 0;
                    @(posedge clock);
                    @(negedge clock);
                    while (pend_itag.size() != 0) begin
                        @(negedge clock);
                    end
                end
                4'h3: begin
                    assert (sweep_hits == ICACHE_LINES)
                    else value_mismatch("sweep hit count", 64'(sweep_hits), 64'(ICACHE_LINES));
                    accept_enable = 1'b1;
                end
                default: begin
                    @(posedge clock);
                    read_addrs <= pair;
                    @(negedge clock);
                    if (!accept_enable) begin
                        sweep_hits += int'(pair[0].valid && cache_outs[0].valid);
                        sweep_hits += int'(pair[1].valid && cache_outs[1].valid);
                    end else begin
                        while (!pair_served(pair)) begin
                            @(posedge clock);
                            @(negedge clock);
                        end
                    end
                end
            endcase
        end
        @(posedge clock);
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/icache_cases.txt
// Columns: control, port 0 address, port 1 address
// Control: 1xxxxxxx run, 2xxxxxxx sweep start, 3xxxxxxx sweep check, F0000000 end, else bits 1:0 valid
10000000 00000000 00000000 // memory accepting
00000000 00000000 00000000 // no reads
00000001 00000008 00000000 // tag 1 on port 0
00000003 00000010 00000018 // tags 2 and 3 both miss
00000003 0000000c 00000020 // tag 1 hits, tag 4 misses
00000002 00000000 00000028 // port 1 alone, tag 5
00000003 00000030 00000014 // tag 6, tag 2 again
00000003 00000038 00000040 // tags 7 and 8 fill the cache
00000003 00000048 00000050 // tags 9 and 10 evict
00000003 00000008 00000010 // revisit tags 1 and 2
00000003 0000001c 00000024 // revisit tags 3 and 4
00000003 00000020 00000028
00000001 00000030 00000000
00000003 00000048 0000003c
20000000 00000000 00000000 // sweep, memory held off
00000003 00000008 00000010
00000003 00000018 00000020
00000003 00000028 00000030
00000003 00000038 00000040
00000003 00000048 00000050
30000000 00000000 00000000 // expect one hit per line
F0000000 00000000 00000000

// File: list.f
rtl/icache_pkg.sv
rtl/icache_array.sv
rtl/icache_victim_select.sv
rtl/icache_mshr.sv
rtl/icache_miss_filter.sv
rtl/icache_subsystem.sv
test/clock_gen.sv
test/icache_subsystem_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module icache_subsystem_tb -o icache_sim > sim.log 2>&1 &&
./obj_dir/icache_sim >> sim.log 2>&1 ||
echo "Build or simulation returned an error" >> sim.log
grep -q "^TEST PASS$" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
